/* test/lpf_stim.txt */
# B = input block to drive, E = expected out_o, lane 0 first, 12-bit hex
# An E line checks the block driven three B lines before the latest B line
B 000 000 000 000 000 000 000 000
B 000 000 000 000 000 000 000 000
B 000 000 000 000 000 000 000 000
B 400 000 000 000 000 000 000 000
E 000 000 000 000 000 000 000 000
B 000 400 000 000 000 000 000 000
E 000 000 000 000 000 000 000 000
B 000 000 400 000 000 000 000 000
E 000 000 000 000 000 000 000 000
B 000 000 000 400 000 000 000 000
E 000 FFF 000 003 000 FEF 000 008
B 000 000 000 000 400 000 000 000
E 000 FE2 FFF 034 003 F9B FEF 143
B 000 000 000 000 000 400 000 000
E 208 143 FE2 F9A 034 037 F9B FD1
B 000 000 000 000 000 000 400 000
E 143 210 143 FD1 F9A 037 037 F9A
B 000 000 000 000 000 000 000 400
E FD1 143 210 143 FD1 F9A 037 037
B 000 000 000 000 000 000 000 000
E F9A FD1 143 210 143 FD1 F9A 037
B 000 000 000 000 000 000 000 000
E 037 F9A FD1 143 210 143 FD1 F9A
B 000 000 000 000 000 000 000 000
E 037 037 F9A FD1 143 210 143 FD1
B 000 000 000 000 000 000 000 000
E F9A 037 037 F9A FD1 143 210 143
B 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
E FD1 F9B 037 034 F9A FE2 143 208
B 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
E 143 FEF F9B 003 034 FFF FE2 000
B 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
E 008 000 FEF 000 003 000 FFF 000
B 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
B 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
B 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
B 3E8 C18 3E8 C18 3E8 C18 3E8 C18
B 3E8 C18 3E8 C18 3E8 C18 3E8 C18
E 3C8 3C8 3C8 3C8 3C8 3C8 3C8 3C8
B 3E8 C18 3E8 C18 3E8 C18 3E8 C18
E 3C8 3C8 3C8 3C8 3C8 3C8 3C8 3C8
B 3E8 C18 3E8 C18 3E8 C18 3E8 C18
B 3E8 C18 3E8 C18 3E8 C18 3E8 C18
B 3E8 C18 3E8 C18 3E8 C18 3E8 C18
B 800 800 800 800 800 800 800 800
B 800 800 800 800 800 800 800 800
E 01F FE0 01F FE0 01F FE0 01F FE0
B 800 800 800 800 800 800 800 800
E 01F FE0 01F FE0 01F FE0 01F FE0
B 800 800 800 800 800 800 800 800
B 800 800 800 800 800 800 800 800
B 7FF 800 7FF 800 7FF 800 7FF 800
B 7FF 800 7FF 800 7FF 800 7FF 800
B 7FF 800 7FF 800 7FF 800 7FF 800
E 841 841 841 841 841 841 841 841
B 7FF 800 7FF 800 7FF 800 7FF 800
B 7FF 800 7FF 800 7FF 800 7FF 800
B 000 000 000 000 000 000 000 000
B 000 000 000 000 000 000 000 000
B 000 000 000 000 000 000 000 000
E 041 FBE 041 FBE 041 FBE 041 FBE

/* files.f */
+incdir+include
logic/lpf_pkg.sv
logic/sample_window.sv
logic/fold_preadd.sv
logic/coeff_mac.sv
logic/lpf_top.sv
test/tb_lpf_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_lpf_top \
    -o tb_lpf_top

./obj_dir/tb_lpf_top 2>&1 | tee sim.log || true

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

/* test/tb_lpf_top.sv */
`timescale 1ns/1ps

`include "lpf_config.svh"

module tb_lpf_top
    import lpf_pkg::*;
();

    logic   clk_i;
    logic   reset_i;
    block_t in_i;
    block_t out_o;

    int n_checks = 0;

    lpf_top i_lpf_top (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .in_i    (in_i),
        .out_o   (out_o)
    );

    ////////////////////////////////////////
    // Clock and reset
    ////////////////////////////////////////

    always #2 clk_i = ~clk_i;

    initial begin
        clk_i = 1'b0;
        reset_i = 1'b1;
        in_i = '0;
        repeat (8) @(posedge clk_i);
        #0.5;
        reset_i = 1'b0;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset_i !== 1'b0 && cycles < 20) begin
            @(posedge clk_i);
            cycles++;
        end
        if (reset_i !== 1'b0) begin
            stop_with_failure("reset_i was still high after 20 clock cycles");
        end
    endtask

    // New block lands just after the edge and is sampled at the next one
    task automatic drive_block(input block_t blk);
        @(posedge clk_i);
        #0.5;
        in_i = blk;
    endtask

    task automatic check_sample(input int lane, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: out_o[%0d] = 0x%h, expected 0x%h",
                     $time, lane, got, exp);
            stop_with_failure("");
        end
    endtask

    task automatic check_block(input block_t exp);
        for (int lane = 0; lane < `LPF_NSAMPS; lane++) begin
            check_sample(lane, out_o[lane], exp[lane]);
        end
        n_checks++;
    endtask

    ////////////////////////////////////////
    // Stimulus file
    ////////////////////////////////////////

    task automatic run_stim_file();
        int           fd;
        int           n_lines;
        int           n_fields;
        int           n_blocks;
        string        line;
        byte          kind;
        logic [11:0]  v [8];
        block_t       blk;
        fd = $fopen("test/lpf_stim.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open stimulus file test/lpf_stim.txt");
        end
        n_lines = 0;
        n_blocks = 0;
        while (!$feof(fd) && n_lines < 1000) begin
            line = "";
            void'($fgets(line, fd));
            n_lines++;
            // Blank lines and comments
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%c %h %h %h %h %h %h %h %h", kind,
                               v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            if (n_fields != 9) begin
                stop_with_failure($sformatf("malformed stimulus line %0d", n_lines));
            end
            for (int lane = 0; lane < `LPF_NSAMPS; lane++) begin
                blk[lane] = v[lane];
            end
            if (kind == "B") begin
                drive_block(blk);
                n_blocks++;
            end else if (kind == "E") begin
                // Output trails the input by three blocks
                if (n_blocks < 4) begin
                    stop_with_failure($sformatf("expected block on line %0d comes too early",
                                                n_lines));
                end
                check_block(blk);
            end else begin
                stop_with_failure($sformatf("unknown line kind on line %0d", n_lines));
            end
        end
        if (!$feof(fd)) begin
            stop_with_failure("stimulus file still not at its end after 1000 lines");
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        wait_reset_release();
        run_stim_file();
        if (n_checks == 0) begin
            stop_with_failure("the stimulus file held no expected blocks");
        end else begin
            $display("%0d output blocks compared", n_checks);
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* logic/lpf_top.sv */
`timescale 1ns/1ps

`include "lpf_config.svh"

module lpf_top
    import lpf_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,
    input  block_t in_i,
    output block_t out_o
);

    ////////////////////////////////////////
    // Shared tap window
    ////////////////////////////////////////

    window_t win;

    sample_window i_sample_window (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .blk_i   (in_i),
        .win_o   (win)
    );

    ////////////////////////////////////////
    // Lane pipelines
    ////////////////////////////////////////

    // Three cycles from input block to output block in every lane
    for (genvar lane = 0; lane < `LPF_NSAMPS; lane++) begin : g_lane
        folded_t fold;

        fold_preadd #(
            .LANE (lane)
        ) i_fold_preadd (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .win_i   (win),
            .fold_o  (fold)
        );

        coeff_mac i_coeff_mac (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .fold_i  (fold),
            .y_o     (out_o[lane])
        );
    end

endmodule

/* logic/coeff_mac.sv */
`timescale 1ns/1ps

`include "lpf_config.svh"

module coeff_mac
    import lpf_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  folded_t fold_i,
    output sample_t y_o
);

    // Centre weight is one half in Q.15, so one bit short of the output shift
    localparam int CENTER_SHIFT = `LPF_OUT_SHIFT - 1;

    // Worst case of 12-bit inputs against this coefficient set stays below 2^30
    localparam int SUM_BITS = 31;

    ////////////////////////////////////////
    // Product stage
    ////////////////////////////////////////

    acc_t    prod_q [`LPF_NPAIRS];
    // Centre sample rides along with the products
    sample_t center_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int m = 0; m < `LPF_NPAIRS; m++) begin
                prod_q[m] <= '0;
            end
            center_q <= '0;
        end else begin
            for (int m = 0; m < `LPF_NPAIRS; m++) begin
                prod_q[m] <= fold_i.pairs[m] * lpf_coef[m];
            end
            center_q <= fold_i.center;
        end
    end

    ////////////////////////////////////////
    // Sum stage
    ////////////////////////////////////////

    acc_t sum_d;
    acc_t sum_q;

    always_comb begin
        // Centre tap as a shift, sign kept by the cast
        sum_d = acc_t'(center_q) <<< CENTER_SHIFT;
        for (int m = 0; m < `LPF_NPAIRS; m++) begin
            sum_d = sum_d + prod_q[m];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum_d;
        end
    end

    // Integer part of the Q.15 sum
    // Dropping low bits floors the value, dropping high bits wraps it
    assign y_o = sum_q[`LPF_OUT_SHIFT +: `LPF_NBITS];

    // Upper accumulator bits must all copy the sign
    a_sum_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (&sum_q[`LPF_ACC_W-1:SUM_BITS-1]) || !(|sum_q[`LPF_ACC_W-1:SUM_BITS-1])
    ) else $error("coeff_mac: sum %0d exceeds %0d bits", sum_q, SUM_BITS);

endmodule

/* logic/fold_preadd.sv */
`timescale 1ns/1ps

`include "lpf_config.svh"

module fold_preadd
    import lpf_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic    clk_i,
    input  logic    reset_i,
    input  window_t win_i,
    output folded_t fold_o
);

    // Window position of x[t] for this lane, tap k sits at NEWEST - k
    localparam int NEWEST = LANE + `LPF_NHIST * `LPF_NSAMPS;

    if (LANE < 0 || LANE >= `LPF_NSAMPS) begin : g_bad_lane
        $error("fold_preadd: LANE %0d outside 0..%0d", LANE, `LPF_NSAMPS - 1);
    end

    if (LPF_NTAPS - 1 > `LPF_NHIST * `LPF_NSAMPS) begin : g_short_hist
        $error("fold_preadd: history too short for %0d taps", LPF_NTAPS);
    end

    ////////////////////////////////////////
    // Mirror pair sums
    ////////////////////////////////////////

    folded_t fold_d;

    always_comb begin
        for (int m = 0; m < `LPF_NPAIRS; m++) begin
            // Taps 2m+1 and NTAPS-2-2m share one coefficient
            fold_d.pairs[m] = pair_t'(win_i[NEWEST - (2 * m + 1)])
                            + pair_t'(win_i[NEWEST - (LPF_NTAPS - 2 - 2 * m)]);
        end
        // Centre tap goes through unfolded
        fold_d.center = win_i[NEWEST - LPF_CENTER];
    end

    ////////////////////////////////////////
    // Pre-add register
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fold_o <= '0;
        end else begin
            fold_o <= fold_d;
        end
    end

endmodule

/* logic/sample_window.sv */
`timescale 1ns/1ps

`include "lpf_config.svh"

module sample_window
    import lpf_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  block_t  blk_i,
    output window_t win_o
);

    ////////////////////////////////////////
    // Block history
    ////////////////////////////////////////

    // Index 0 is the oldest stored block
    block_t [`LPF_NHIST-1:0] hist_q;

    // One block in, oldest block out, every clock
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hist_q <= '0;
        end else begin
            hist_q <= {blk_i, hist_q[`LPF_NHIST-1:1]};
        end
    end

    ////////////////////////////////////////
    // Tap window
    ////////////////////////////////////////

    // Live block on top so the newest sample sits at the highest position
    assign win_o = {blk_i, hist_q};

    // Unknown input would spread through every lane for four blocks
    a_blk_known: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !$isunknown(blk_i)
    ) else $error("sample_window: unknown bits on blk_i");

endmodule

/* logic/lpf_pkg.sv */
`include "lpf_config.svh"

package lpf_pkg;

    ////////////////////////////////////////
    // Derived sizes
    ////////////////////////////////////////

    // Stored blocks plus the live one
    localparam int LPF_NWIN = (`LPF_NHIST + 1) * `LPF_NSAMPS;
    // Two non-zero odd taps per pair, even taps zero except the centre
    localparam int LPF_NTAPS = 4 * `LPF_NPAIRS + 1;
    localparam int LPF_CENTER = (LPF_NTAPS - 1) / 2;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    typedef logic signed [`LPF_NBITS-1:0] sample_t;

    // Lane 0 holds the oldest sample of the block
    typedef sample_t [`LPF_NSAMPS-1:0] block_t;

    // Position 0 is the oldest sample, top position the newest
    typedef sample_t [LPF_NWIN-1:0] window_t;

    // One extra bit for the sum of two mirror samples
    typedef logic signed [`LPF_NBITS:0] pair_t;

    typedef struct packed {
        pair_t [`LPF_NPAIRS-1:0] pairs;
        sample_t                 center;
    } folded_t;

    typedef logic signed [`LPF_COEF_W-1:0] coef_t;
    typedef logic signed [`LPF_ACC_W-1:0] acc_t;

    // Entry m weights taps 2m+1 and 31-2m, Q3.15
    // Centre tap 16 is one half and is done as a shift
    localparam coef_t lpf_coef [`LPF_NPAIRS] = '{
        -18'sd23, 18'sd105, -18'sd526, 18'sd263,
        -18'sd949, 18'sd1672, -18'sd3216, 18'sd10342
    };

endpackage

/* include/lpf_config.svh */
`ifndef LPF_CONFIG_SVH
`define LPF_CONFIG_SVH

// Samples per block, one per lane every clock
`define LPF_NSAMPS 8

// Signed sample width at input and output
`define LPF_NBITS 12

// Past blocks kept for the tap window
`define LPF_NHIST 4

// Non-zero mirror tap pairs of the half-band set
`define LPF_NPAIRS 8

// Coefficient width, Q3.15
`define LPF_COEF_W 18

// Accumulator width, Q24.24 style headroom
`define LPF_ACC_W 48

// Fraction bits dropped when slicing the output
`define LPF_OUT_SHIFT 15

`endif
